/* include/immu_consts.svh */
/* Widths and sizes shared by the fetch translation stage.
   Page numbers are IMMU_DW - IMMU_PAGE_SHIFT bits wide. */
`ifndef IMMU_CONSTS_SVH
`define IMMU_CONSTS_SVH

// Datapath widths
`define IMMU_AW 32
`define IMMU_DW 32
`define IMMU_IW 32

// 8 KiB pages
`define IMMU_PAGE_SHIFT 13

// First fetch address out of reset
`define IMMU_RESET_VECTOR 32'h0000_0100

// Default TLB depth, 128 sets
`define IMMU_TLB_NSETS_LOG2 7

// Instruction RAM depth in words, wraps above this
`define IMMU_IMEM_WORDS_LOG2 8

`endif

/* verilog/immu_pkg.sv */
/* Address, instruction and TLB entry types.
   Low word holds V and VPN, high word holds P, UX, RX, S and PPN. */
`include "immu_consts.svh"
`default_nettype none

package immu_pkg;

   typedef logic [`IMMU_AW-1:0] vaddr_t;
   typedef logic [`IMMU_AW-1:0] paddr_t;
   typedef logic [`IMMU_IW-1:0] insn_t;
   typedef logic [`IMMU_DW-1:0] tlb_word_t;

   // Page numbers fill the bits above the page offset
   typedef logic [`IMMU_DW-`IMMU_PAGE_SHIFT-1:0] vpn_t;
   typedef logic [`IMMU_DW-`IMMU_PAGE_SHIFT-1:0] ppn_t;

   // TLB low half, bit 0 is V
   typedef struct packed {
      vpn_t                          vpn;
      logic [`IMMU_PAGE_SHIFT-2:0]   rsv;
      logic                          v;
   } tlb_lo_t;

   // TLB high half, P at 0, UX at 3, RX at 4, S at 8
   typedef struct packed {
      ppn_t                          ppn;
      logic [`IMMU_PAGE_SHIFT-10:0]  rsv_hi;
      logic                          s;
      logic [2:0]                    rsv_mid;
      logic                          rx;
      logic                          ux;
      logic [1:0]                    rsv_lo;
      logic                          p;
   } tlb_hi_t;

endpackage

`default_nettype wire

/* verilog/pipe_buf.sv */
/* One-entry valid/ready buffer, output always registered.
   bypass lets a new item enter in the cycle the held one drains. */
`default_nettype none

module pipe_buf #(
   parameter type payload_t = logic,
   parameter bit  bypass    = 1'b0
) (
   input  wire           clk,
   input  wire           rst_n,
   input  wire           in_valid,
   output logic          in_ready,
   input  wire payload_t din,
   output logic          out_valid,
   input  wire           out_ready,
   output payload_t      dout,
   output logic          xfer
);

   logic     full_r;
   payload_t data_r;

   // Without bypass the slot must be empty first
   assign in_ready = bypass ? (~full_r | out_ready) : ~full_r;
   assign xfer     = in_valid & in_ready;

   // Occupancy, refill wins over drain
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         full_r <= 1'b0;
      end else begin
         full_r <= xfer | (full_r & ~out_ready);
      end
   end

   // Payload only moves on an input handshake
   always_ff @(posedge clk) begin
      if (xfer) begin
         data_r <= din;
      end
   end

   assign out_valid = full_r;
   assign dout      = data_r;

endmodule

`default_nettype wire

/* verilog/tlb_ram.sv */
/* TLB half storage, 2**TLB_NSETS_LOG2 words, all cleared by reset.
   Port A is lookup only, port B writes and reads back the same index. */
`include "immu_consts.svh"
`default_nettype none

module tlb_ram
   import immu_pkg::*;
#(
   parameter int TLB_NSETS_LOG2 = `IMMU_TLB_NSETS_LOG2
) (
   input  wire                      clk,
   input  wire                      rst_n,
   // Lookup port
   input  wire [TLB_NSETS_LOG2-1:0] addr_a,
   input  wire                      re_a,
   output tlb_word_t                dout_a,
   // Register port
   input  wire [TLB_NSETS_LOG2-1:0] addr_b,
   input  wire                      we_b,
   input  wire tlb_word_t           din_b,
   output tlb_word_t                dout_b
);

   localparam int NSETS = 1 << TLB_NSETS_LOG2;

   tlb_word_t mem [NSETS];

   // Entries start with V clear
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NSETS; i++) begin
            mem[i] <= '0;
         end
      end else if (we_b) begin
         mem[addr_b] <= din_b;
      end
   end

   // Lookup result holds until the next enabled read
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dout_a <= '0;
      end else if (re_a) begin
         dout_a <= mem[addr_a];
      end
   end

   // Readback, old data on a same-cycle write
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dout_b <= '0;
      end else begin
         dout_b <= mem[addr_b];
      end
   end

endmodule

`default_nettype wire

/* verilog/immu.sv */
/* Direct-mapped instruction TLB, one fetch in flight to memory.
   Responses already accepted by memory are not cancelled by a flush.
   TLB_NSETS_LOG2 must not exceed the VPN width. */
`include "immu_consts.svh"
`default_nettype none

module immu
   import immu_pkg::*;
#(
   parameter int TLB_NSETS_LOG2 = `IMMU_TLB_NSETS_LOG2
) (
   input  wire                      clk,
   input  wire                      rst_n,
   // Fetch command and response
   input  wire                      ibus_cmd_valid,
   output logic                     ibus_cmd_ready,
   input  wire vaddr_t              ibus_cmd_addr,
   output logic                     ibus_valid,
   input  wire                      ibus_ready,
   output insn_t                    ibus_dout,
   input  wire                      ibus_flush_req,
   output logic                     ibus_flush_ack,
   output vaddr_t                   ibus_out_id,
   output vaddr_t                   ibus_out_id_nxt,
   // Memory side
   output logic                     imem_cmd_valid,
   input  wire                      imem_cmd_ready,
   output paddr_t                   imem_cmd_addr,
   input  wire                      imem_valid,
   output logic                     imem_ready,
   input  wire insn_t               imem_dout,
   // Exceptions and mode
   output logic                     exp_tlb_miss,
   output logic                     exp_page_fault,
   input  wire                      psr_imme,
   input  wire                      psr_rm,
   output tlb_word_t                immid,
   // TLB register ports
   input  wire [TLB_NSETS_LOG2-1:0] tlbl_idx,
   input  wire tlb_word_t           tlbl_wdata,
   input  wire                      tlbl_we,
   output tlb_word_t                tlbl_rdata,
   input  wire [TLB_NSETS_LOG2-1:0] tlbh_idx,
   input  wire tlb_word_t           tlbh_wdata,
   input  wire                      tlbh_we,
   output tlb_word_t                tlbh_rdata
);

   localparam int PAGE_SHIFT = `IMMU_PAGE_SHIFT;

   logic      cmd_xfer;
   logic      cmd_pend;
   vaddr_t    cmd_vaddr;
   logic      flush_seen_r;
   logic      flush_strobe;
   logic      imem_cmd_hds;
   logic      ibus_rsp_hds;
   logic      imme_r;
   logic      rm_r;
   tlb_word_t tlb_l_r;
   tlb_word_t tlb_h_r;
   tlb_lo_t   tlb_lo;
   tlb_hi_t   tlb_hi;
   vpn_t      cmd_vpn;
   logic      perm_denied;
   logic      miss_nxt;
   logic      fault_nxt;

   if (TLB_NSETS_LOG2 > $bits(vpn_t)) begin : g_bad_nsets
      $fatal(1, "TLB index wider than the VPN");
   end

   ////////////////////////////////////////////////////////////
   // Flush and command buffer
   ////////////////////////////////////////////////////////////

   // First cycle of a flush request
   assign flush_strobe = ibus_flush_req & ~flush_seen_r;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         flush_seen_r <= 1'b0;
      end else begin
         flush_seen_r <= ibus_flush_req & ~ibus_flush_ack;
      end
   end

   // Holds the fetch address between TLB read and memory handshake;
   // a flush drains it so the ibus handshake is never blocked
   pipe_buf #(
      .payload_t (vaddr_t),
      .bypass    (1'b1)
   ) u_cmd_buf (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (ibus_cmd_valid),
      .in_ready  (ibus_cmd_ready),
      .din       (ibus_cmd_addr),
      .out_valid (cmd_pend),
      .out_ready (imem_cmd_ready | ibus_flush_req),
      .dout      (cmd_vaddr),
      .xfer      (cmd_xfer)
   );

   // Cancelled commands never reach memory
   assign imem_cmd_valid = cmd_pend & ~ibus_flush_req;
   assign imem_cmd_hds   = imem_cmd_valid & imem_cmd_ready;

   // Redirect taken by the handshake after the strobe
   assign ibus_flush_ack = ibus_flush_req & cmd_xfer & ~flush_strobe;

   // Response path straight through
   assign ibus_valid   = imem_valid;
   assign ibus_dout    = imem_dout;
   assign imem_ready   = ibus_ready;
   assign ibus_rsp_hds = ibus_valid & ibus_ready;

   ////////////////////////////////////////////////////////////
   // PC tracking
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ibus_out_id_nxt <= `IMMU_RESET_VECTOR;
      end else if (cmd_xfer) begin
         ibus_out_id_nxt <= ibus_cmd_addr;
      end
   end

   // Flush address takes priority over the delivered stream
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ibus_out_id <= `IMMU_RESET_VECTOR;
      end else if (ibus_flush_req) begin
         ibus_out_id <= ibus_cmd_addr;
      end else if (ibus_rsp_hds) begin
         ibus_out_id <= ibus_out_id_nxt;
      end
   end

   assign immid = tlb_word_t'(TLB_NSETS_LOG2);

   ////////////////////////////////////////////////////////////
   // TLB lookup and checks
   ////////////////////////////////////////////////////////////

   // Mode sampled with the address
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         imme_r <= 1'b0;
         rm_r   <= 1'b0;
      end else if (cmd_xfer) begin
         imme_r <= psr_imme;
         rm_r   <= psr_rm;
      end
   end

   tlb_ram #(
      .TLB_NSETS_LOG2 (TLB_NSETS_LOG2)
   ) u_tlb_lo (
      .clk    (clk),
      .rst_n  (rst_n),
      .addr_a (ibus_cmd_addr[PAGE_SHIFT +: TLB_NSETS_LOG2]),
      .re_a   (cmd_xfer),
      .dout_a (tlb_l_r),
      .addr_b (tlbl_idx),
      .we_b   (tlbl_we),
      .din_b  (tlbl_wdata),
      .dout_b (tlbl_rdata)
   );

   tlb_ram #(
      .TLB_NSETS_LOG2 (TLB_NSETS_LOG2)
   ) u_tlb_hi (
      .clk    (clk),
      .rst_n  (rst_n),
      .addr_a (ibus_cmd_addr[PAGE_SHIFT +: TLB_NSETS_LOG2]),
      .re_a   (cmd_xfer),
      .dout_a (tlb_h_r),
      .addr_b (tlbh_idx),
      .we_b   (tlbh_we),
      .din_b  (tlbh_wdata),
      .dout_b (tlbh_rdata)
   );

   assign tlb_lo  = tlb_lo_t'(tlb_l_r);
   assign tlb_hi  = tlb_hi_t'(tlb_h_r);
   assign cmd_vpn = cmd_vaddr[`IMMU_AW-1:PAGE_SHIFT];

   // Root mode checks RX, user mode UX
   assign perm_denied = rm_r ? ~tlb_hi.rx : ~tlb_hi.ux;
   assign miss_nxt    = imme_r & ~(tlb_lo.v & (tlb_lo.vpn == cmd_vpn));
   // Fault only counts on a hit
   assign fault_nxt   = imme_r & ~miss_nxt & perm_denied;

   // Flags travel with the memory request
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         exp_tlb_miss   <= 1'b0;
         exp_page_fault <= 1'b0;
      end else if (imem_cmd_hds) begin
         exp_tlb_miss   <= miss_nxt;
         exp_page_fault <= fault_nxt;
      end
   end

   // Untranslated when the MMU is off
   assign imem_cmd_addr = imme_r ? {tlb_hi.ppn, cmd_vaddr[PAGE_SHIFT-1:0]} : cmd_vaddr;

endmodule

`default_nettype wire

/* verilog/imem.sv */
/* Word RAM in place of the icache, indexed by address bits 9 to 2.
   Loads go straight to the array; one response is held at a time. */
`include "immu_consts.svh"
`default_nettype none

module imem
   import immu_pkg::*;
(
   input  wire         clk,
   input  wire         rst_n,
   // Preload port
   input  wire         load_we,
   input  wire paddr_t load_addr,
   input  wire insn_t  load_data,
   // Fetch command
   input  wire         cmd_valid,
   output logic        cmd_ready,
   input  wire paddr_t cmd_addr,
   // Fetch response
   output logic        rsp_valid,
   input  wire         rsp_ready,
   output insn_t       rsp_data
);

   localparam int IDX_W = `IMMU_IMEM_WORDS_LOG2;
   localparam int DEPTH = 1 << IDX_W;

   insn_t            mem [DEPTH];
   logic [IDX_W-1:0] load_idx;
   logic [IDX_W-1:0] cmd_idx;
   insn_t            rd_word;

   // Word addressed, upper bits ignored
   assign load_idx = load_addr[IDX_W+1:2];
   assign cmd_idx  = cmd_addr[IDX_W+1:2];

   always_ff @(posedge clk) begin
      if (load_we) begin
         mem[load_idx] <= load_data;
      end
   end

   assign rd_word = mem[cmd_idx];

   // No bypass, so a held response blocks the next command
   pipe_buf #(
      .payload_t (insn_t),
      .bypass    (1'b0)
   ) u_rsp_buf (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (cmd_valid),
      .in_ready  (cmd_ready),
      .din       (rd_word),
      .out_valid (rsp_valid),
      .out_ready (rsp_ready),
      .dout      (rsp_data),
      .xfer      ()
   );

endmodule

`default_nettype wire

/* verilog/ifetch_top.sv */
/* Fetch translation stage with its instruction RAM.
   Memory contents come only from the load port. */
`include "immu_consts.svh"
`default_nettype none

module ifetch_top
   import immu_pkg::*;
#(
   parameter int TLB_NSETS_LOG2 = `IMMU_TLB_NSETS_LOG2
) (
   input  wire                      clk,
   input  wire                      rst_n,
   // Fetch unit
   input  wire                      ibus_cmd_valid,
   output logic                     ibus_cmd_ready,
   input  wire vaddr_t              ibus_cmd_addr,
   output logic                     ibus_valid,
   input  wire                      ibus_ready,
   output insn_t                    ibus_dout,
   input  wire                      ibus_flush_req,
   output logic                     ibus_flush_ack,
   output vaddr_t                   ibus_out_id,
   output vaddr_t                   ibus_out_id_nxt,
   // Exceptions and mode
   output logic                     exp_tlb_miss,
   output logic                     exp_page_fault,
   input  wire                      psr_imme,
   input  wire                      psr_rm,
   output tlb_word_t                immid,
   // TLB register ports
   input  wire [TLB_NSETS_LOG2-1:0] tlbl_idx,
   input  wire tlb_word_t           tlbl_wdata,
   input  wire                      tlbl_we,
   output tlb_word_t                tlbl_rdata,
   input  wire [TLB_NSETS_LOG2-1:0] tlbh_idx,
   input  wire tlb_word_t           tlbh_wdata,
   input  wire                      tlbh_we,
   output tlb_word_t                tlbh_rdata,
   // Memory preload
   input  wire                      load_we,
   input  wire paddr_t              load_addr,
   input  wire insn_t               load_data
);

   logic   imem_cmd_valid;
   logic   imem_cmd_ready;
   paddr_t imem_cmd_addr;
   logic   imem_valid;
   logic   imem_ready;
   insn_t  imem_dout;

   immu #(
      .TLB_NSETS_LOG2 (TLB_NSETS_LOG2)
   ) u_immu (
      .clk             (clk),
      .rst_n           (rst_n),
      .ibus_cmd_valid  (ibus_cmd_valid),
      .ibus_cmd_ready  (ibus_cmd_ready),
      .ibus_cmd_addr   (ibus_cmd_addr),
      .ibus_valid      (ibus_valid),
      .ibus_ready      (ibus_ready),
      .ibus_dout       (ibus_dout),
      .ibus_flush_req  (ibus_flush_req),
      .ibus_flush_ack  (ibus_flush_ack),
      .ibus_out_id     (ibus_out_id),
      .ibus_out_id_nxt (ibus_out_id_nxt),
      .imem_cmd_valid  (imem_cmd_valid),
      .imem_cmd_ready  (imem_cmd_ready),
      .imem_cmd_addr   (imem_cmd_addr),
      .imem_valid      (imem_valid),
      .imem_ready      (imem_ready),
      .imem_dout       (imem_dout),
      .exp_tlb_miss    (exp_tlb_miss),
      .exp_page_fault  (exp_page_fault),
      .psr_imme        (psr_imme),
      .psr_rm          (psr_rm),
      .immid           (immid),
      .tlbl_idx        (tlbl_idx),
      .tlbl_wdata      (tlbl_wdata),
      .tlbl_we         (tlbl_we),
      .tlbl_rdata      (tlbl_rdata),
      .tlbh_idx        (tlbh_idx),
      .tlbh_wdata      (tlbh_wdata),
      .tlbh_we         (tlbh_we),
      .tlbh_rdata      (tlbh_rdata)
   );

   imem u_imem (
      .clk       (clk),
      .rst_n     (rst_n),
      .load_we   (load_we),
      .load_addr (load_addr),
      .load_data (load_data),
      .cmd_valid (imem_cmd_valid),
      .cmd_ready (imem_cmd_ready),
      .cmd_addr  (imem_cmd_addr),
      .rsp_valid (imem_valid),
      .rsp_ready (imem_ready),
      .rsp_data  (imem_dout)
   );

endmodule

`default_nettype wire

/* dv/immu_props.sv */
/* Protocol rules on the MMU fetch side, bound to every immu instance.
   All rules are off while rst_n is low. */
`default_nettype none

module immu_props
   import immu_pkg::*;
(
   input wire        clk,
   input wire        rst_n,
   input wire        ibus_cmd_valid,
   input wire        ibus_cmd_ready,
   input wire        ibus_flush_req,
   input wire        ibus_valid,
   input wire        ibus_ready,
   input wire insn_t ibus_dout,
   input wire        exp_tlb_miss,
   input wire        exp_page_fault
);

   int fail_count;

   initial begin
      fail_count = 0;
   end

   // A fetch is a miss or a fault, never both
   a_one_exception: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(exp_tlb_miss && exp_page_fault)
   ) else begin
      $error("TLB miss and page fault raised together");
      fail_count++;
   end

   // Redirect address is always taken while flushing
   a_flush_handshake: assert property (
      @(posedge clk) disable iff (!rst_n)
      ibus_flush_req |-> (ibus_cmd_valid && ibus_cmd_ready)
   ) else begin
      $error("No command handshake during a flush request");
      fail_count++;
   end

   // Held response keeps its word
   a_rsp_stable: assert property (
      @(posedge clk) disable iff (!rst_n)
      (ibus_valid && !ibus_ready) |=> (ibus_valid && $stable(ibus_dout))
   ) else begin
      $error("Response dropped or changed while stalled");
      fail_count++;
   end

endmodule

`default_nettype wire

/* dv/immu_tb.sv */
/* Directed fetches with the MMU off and on, TLB readback, flush and
   a stalled stream. Single fetches wait for their response first. */
`include "immu_consts.svh"
`default_nettype none

module immu_tb
   import immu_pkg::*;
();

   localparam int IDX_W      = `IMMU_TLB_NSETS_LOG2;
   localparam int WORDS      = 1 << `IMMU_IMEM_WORDS_LOG2;
   localparam int WAIT_LIMIT = 200;
   localparam int STREAM_LEN = 24;

   logic             clk;
   logic             rst_n;
   logic             ibus_cmd_valid;
   logic             ibus_cmd_ready;
   vaddr_t           ibus_cmd_addr;
   logic             ibus_valid;
   logic             ibus_ready;
   insn_t            ibus_dout;
   logic             ibus_flush_req;
   logic             ibus_flush_ack;
   vaddr_t           ibus_out_id;
   vaddr_t           ibus_out_id_nxt;
   logic             exp_tlb_miss;
   logic             exp_page_fault;
   logic             psr_imme;
   logic             psr_rm;
   tlb_word_t        immid;
   logic [IDX_W-1:0] tlbl_idx;
   tlb_word_t        tlbl_wdata;
   logic             tlbl_we;
   tlb_word_t        tlbl_rdata;
   logic [IDX_W-1:0] tlbh_idx;
   tlb_word_t        tlbh_wdata;
   logic             tlbh_we;
   tlb_word_t        tlbh_rdata;
   logic             load_we;
   paddr_t           load_addr;
   insn_t            load_data;

   int     seed;
   insn_t  model_mem [WORDS];
   insn_t  exp_q [$];
   vaddr_t va;
   vpn_t   vpn;
   vpn_t   vpn_x;
   ppn_t   ppn;
   logic [`IMMU_PAGE_SHIFT-1:0] off;

   ifetch_top dut (.*);

   bind immu immu_props u_props (
      .clk            (clk),
      .rst_n          (rst_n),
      .ibus_cmd_valid (ibus_cmd_valid),
      .ibus_cmd_ready (ibus_cmd_ready),
      .ibus_flush_req (ibus_flush_req),
      .ibus_valid     (ibus_valid),
      .ibus_ready     (ibus_ready),
      .ibus_dout      (ibus_dout),
      .exp_tlb_miss   (exp_tlb_miss),
      .exp_page_fault (exp_page_fault)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // Reference model and checks
   ////////////////////////////////////////////////////////////

   // RAM wraps every 256 words
   function automatic insn_t model_word(paddr_t pa);
      return model_mem[pa[`IMMU_IMEM_WORDS_LOG2+1:2]];
   endfunction

   // V in bit 0 and the VPN on top
   function automatic tlb_word_t make_lo(vpn_t vpn_i, logic v);
      return {vpn_i, {(`IMMU_PAGE_SHIFT-1){1'b0}}, v};
   endfunction

   // P always set and S left clear
   function automatic tlb_word_t make_hi(ppn_t ppn_i, logic ux, logic rx);
      tlb_word_t w;
      w    = {ppn_i, {`IMMU_PAGE_SHIFT{1'b0}}};
      w[0] = 1'b1;
      w[3] = ux;
      w[4] = rx;
      return w;
   endfunction

   task automatic stop_run(string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped");
   endtask

   task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
      assert (act === exp) else begin
         stop_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
      end
   endtask

   // Protocol assertion failures end the run too
   always @(negedge clk) begin
      if (dut.u_immu.u_props.fail_count != 0) begin
         stop_run("A bound protocol assertion failed");
      end
   end

   ////////////////////////////////////////////////////////////
   // Bus tasks
   ////////////////////////////////////////////////////////////

   task automatic send_cmd(vaddr_t addr);
      int n;
      ibus_cmd_valid = 1'b1;
      ibus_cmd_addr  = addr;
      n = 0;
      @(negedge clk);
      while (!ibus_cmd_ready) begin
         n++;
         if (n > WAIT_LIMIT) stop_run("Timeout waiting for the fetch command handshake");
         @(negedge clk);
      end
      @(posedge clk);
      #2;
      ibus_cmd_valid = 1'b0;
   endtask

   // White-box look at the translated memory address
   task automatic expect_paddr(string name, paddr_t pa);
      int n;
      n = 0;
      @(negedge clk);
      while (!dut.imem_cmd_valid) begin
         n++;
         if (n > WAIT_LIMIT) stop_run("Timeout waiting for the memory command");
         @(negedge clk);
      end
      check_value({name, " paddr"}, pa, dut.imem_cmd_addr);
   endtask

   // Expects ibus_ready high so the response is taken at once
   task automatic take_response(string name, insn_t word, logic chk_word,
                                logic miss, logic fault, vaddr_t id);
      int n;
      n = 0;
      @(negedge clk);
      while (!ibus_valid) begin
         n++;
         if (n > WAIT_LIMIT) stop_run("Timeout waiting for the fetch response");
         @(negedge clk);
      end
      if (chk_word) begin
         check_value({name, " word"}, word, ibus_dout);
      end
      check_value({name, " tlb miss"}, miss, exp_tlb_miss);
      check_value({name, " page fault"}, fault, exp_page_fault);
      @(posedge clk);
      #2;
      check_value({name, " out id"}, id, ibus_out_id);
   endtask

   task automatic fetch(string name, vaddr_t addr, logic imme, logic rm,
                        paddr_t pa, logic miss, logic fault);
      psr_imme = imme;
      psr_rm   = rm;
      send_cmd(addr);
      // Next id follows the accepted command
      check_value({name, " out id nxt"}, addr, ibus_out_id_nxt);
      // Address only defined for a clean fetch
      if (!miss && !fault) begin
         expect_paddr(name, pa);
      end
      take_response(name, model_word(pa), !miss && !fault, miss, fault, addr);
   endtask

   task automatic write_tlb(logic [IDX_W-1:0] idx, tlb_word_t lo, tlb_word_t hi);
      tlbl_idx   = idx;
      tlbh_idx   = idx;
      tlbl_wdata = lo;
      tlbh_wdata = hi;
      tlbl_we    = 1'b1;
      tlbh_we    = 1'b1;
      @(posedge clk);
      #2;
      tlbl_we = 1'b0;
      tlbh_we = 1'b0;
   endtask

   task automatic read_tlb(string name, logic [IDX_W-1:0] idx, tlb_word_t lo, tlb_word_t hi);
      tlbl_idx = idx;
      tlbh_idx = idx;
      @(posedge clk);
      #2;
      check_value({name, " low"}, lo, tlbl_rdata);
      check_value({name, " high"}, hi, tlbh_rdata);
   endtask

   // Redirect from idle with the MMU off
   task automatic flush_to(string name, vaddr_t addr);
      int n;
      psr_imme       = 1'b0;
      ibus_flush_req = 1'b1;
      ibus_cmd_valid = 1'b1;
      ibus_cmd_addr  = addr;
      n = 0;
      @(negedge clk);
      while (!ibus_flush_ack) begin
         n++;
         if (n > WAIT_LIMIT) stop_run("Timeout waiting for the flush acknowledge");
         @(negedge clk);
      end
      @(posedge clk);
      #2;
      ibus_flush_req = 1'b0;
      ibus_cmd_valid = 1'b0;
      take_response(name, model_word(addr), 1'b1, 1'b0, 1'b0, addr);
   endtask

   // Back-to-back commands against a random ready pattern
   task automatic stall_stream();
      vaddr_t addrs [STREAM_LEN];
      int     got;
      int     idle;
      for (int i = 0; i < STREAM_LEN; i++) begin
         addrs[i] = $random(seed);
      end
      psr_imme = 1'b0;
      got  = 0;
      idle = 0;
      fork
         begin
            for (int i = 0; i < STREAM_LEN; i++) begin
               exp_q.push_back(model_word(addrs[i]));
               send_cmd(addrs[i]);
            end
         end
         begin
            while (got < STREAM_LEN) begin
               @(posedge clk);
               #2;
               ibus_ready = ($random(seed) % 3) != 0;
               @(negedge clk);
               if (ibus_valid && ibus_ready) begin
                  check_value("stall stream word", exp_q.pop_front(), ibus_dout);
                  got++;
                  idle = 0;
               end else begin
                  idle++;
                  if (idle > WAIT_LIMIT) stop_run("Timeout waiting for a stream response");
               end
            end
         end
      join
      ibus_ready = 1'b1;
      // Nothing left over after the last word
      repeat (4) @(negedge clk);
      check_value("stall stream extra response", 1'b0, ibus_valid);
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////

   initial begin
      seed           = 32'h0b76_b2eb;
      rst_n          = 1'b0;
      ibus_cmd_valid = 1'b0;
      ibus_cmd_addr  = '0;
      ibus_ready     = 1'b0;
      ibus_flush_req = 1'b0;
      psr_imme       = 1'b0;
      psr_rm         = 1'b0;
      tlbl_idx       = '0;
      tlbl_wdata     = '0;
      tlbl_we        = 1'b0;
      tlbh_idx       = '0;
      tlbh_wdata     = '0;
      tlbh_we        = 1'b0;
      load_we        = 1'b0;
      load_addr      = '0;
      load_data      = '0;
      repeat (10) @(posedge clk);
      #2;
      rst_n = 1'b1;

      // Idle state out of reset
      @(negedge clk);
      check_value("reset ibus_valid", 1'b0, ibus_valid);
      check_value("reset imem_cmd_valid", 1'b0, dut.imem_cmd_valid);
      check_value("reset flush ack", 1'b0, ibus_flush_ack);
      check_value("reset tlb miss", 1'b0, exp_tlb_miss);
      check_value("reset page fault", 1'b0, exp_page_fault);
      check_value("reset out id", `IMMU_RESET_VECTOR, ibus_out_id);

      // Preload RAM and model
      @(posedge clk);
      #2;
      for (int i = 0; i < WORDS; i++) begin
         model_mem[i] = $random(seed);
         load_we      = 1'b1;
         load_addr    = paddr_t'(i) << 2;
         load_data    = model_mem[i];
         @(posedge clk);
         #2;
      end
      load_we    = 1'b0;
      ibus_ready = 1'b1;

      // Address passes through with the MMU off
      for (int i = 0; i < 6; i++) begin
         va = $random(seed);
         fetch("mmu off", va, 1'b0, 1'b0, va, 1'b0, 1'b0);
      end

      // Hit in both modes on set 0x45
      vpn = 19'h1_2345;
      ppn = 19'h0_0a7c;
      off = 13'h1a4c;
      write_tlb(vpn[IDX_W-1:0], make_lo(vpn, 1'b1), make_hi(ppn, 1'b1, 1'b1));
      fetch("hit user", {vpn, off}, 1'b1, 1'b0, {ppn, off}, 1'b0, 1'b0);
      fetch("hit root", {vpn, off}, 1'b1, 1'b1, {ppn, off}, 1'b0, 1'b0);

      // Misses on another VPN in a used set, on V clear and on an empty set
      fetch("miss vpn", {vpn ^ 19'h4_0000, off}, 1'b1, 1'b0, '0, 1'b1, 1'b0);
      vpn_x = 19'h0_3a11;
      write_tlb(vpn_x[IDX_W-1:0], make_lo(vpn_x, 1'b0), make_hi(ppn, 1'b1, 1'b1));
      fetch("miss invalid", {vpn_x, off}, 1'b1, 1'b0, '0, 1'b1, 1'b0);
      fetch("miss empty", {19'h7_0a22, off}, 1'b1, 1'b1, '0, 1'b1, 1'b0);

      // UX clear so user mode faults and root mode hits
      vpn_x = 19'h5_5533;
      write_tlb(vpn_x[IDX_W-1:0], make_lo(vpn_x, 1'b1), make_hi(ppn, 1'b0, 1'b1));
      fetch("fault user", {vpn_x, off}, 1'b1, 1'b0, '0, 1'b0, 1'b1);
      fetch("rx root", {vpn_x, off}, 1'b1, 1'b1, {ppn, off}, 1'b0, 1'b0);
      read_tlb("readback ux clear", vpn_x[IDX_W-1:0], make_lo(vpn_x, 1'b1),
               make_hi(ppn, 1'b0, 1'b1));

      // RX clear so root mode faults and user mode hits
      vpn_x = 19'h2_2266;
      write_tlb(vpn_x[IDX_W-1:0], make_lo(vpn_x, 1'b1), make_hi(ppn, 1'b1, 1'b0));
      fetch("fault root", {vpn_x, off}, 1'b1, 1'b1, '0, 1'b0, 1'b1);
      fetch("ux user", {vpn_x, off}, 1'b1, 1'b0, {ppn, off}, 1'b0, 1'b0);

      // Register readback and identity
      read_tlb("readback hit", vpn[IDX_W-1:0], make_lo(vpn, 1'b1), make_hi(ppn, 1'b1, 1'b1));
      read_tlb("readback empty", 7'h22, '0, '0);
      check_value("immid", IDX_W, immid);

      // Redirect and then a stalled stream
      va = $random(seed);
      flush_to("flush", va);
      stall_stream();

      if (dut.u_immu.u_props.fail_count == 0) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         stop_run("A bound protocol assertion failed during the run");
      end
   end

endmodule

`default_nettype wire

/* flist.f */
+incdir+include
verilog/immu_pkg.sv
verilog/pipe_buf.sv
verilog/tlb_ram.sv
verilog/immu.sv
verilog/imem.sv
verilog/ifetch_top.sv
dv/immu_props.sv
dv/immu_tb.sv

/* Bender.yml */
package:
  name: immu

export_include_dirs:
  - include

sources:
  - target: rtl
    include_dirs:
      - include
    files:
      - verilog/immu_pkg.sv
      - verilog/pipe_buf.sv
      - verilog/tlb_ram.sv
      - verilog/immu.sv
      - verilog/imem.sv
      - verilog/ifetch_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/immu_props.sv
      - dv/immu_tb.sv
